// File: files.f
+incdir+include
logic/spu_isa_pkg.sv
logic/odd_pipe_pkg.sv
logic/local_store.sv
logic/odd_exec.sv
logic/pipe_stage.sv
logic/result_collect.sv
logic/odd_pipe.sv
test/odd_pipe_tb.sv

// File: include/odd_settings.svh
`ifndef ODD_SETTINGS_SVH
`define ODD_SETTINGS_SVH

// stages behind exec, stage 1 is filled at issue
`define ODD_DEPTH 7

// local store depth in quadwords (32 KB)
`define LS_ADDR_W 11

// program counter width, word granular
`define PC_W 10

// register file index width, 128 registers
`define REG_W 7

`endif

// File: logic/local_store.sv
`include "odd_settings.svh"

module local_store (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`LS_ADDR_W-1:0] addr,
  input  logic                  we,
  input  logic [127:0]          wdata,
  input  logic                  preload_en,
  input  logic [`LS_ADDR_W-1:0] preload_addr,
  input  logic [127:0]          preload_data,
  output logic [127:0]          rdata
);

  logic [127:0] mem [0:(2**`LS_ADDR_W)-1];

  // preload wins over a store in the same cycle
  always_ff @(posedge clk) begin
    if (preload_en) begin
      mem[preload_addr] <= preload_data;
    end else if (we && !rst) begin  // no stores while core held in reset
      mem[addr] <= wdata;
    end
  end

  // read is combinational, a store from the previous edge is visible
  assign rdata = mem[addr];

endmodule

// File: logic/odd_exec.sv
`include "odd_settings.svh"

module odd_exec
  import spu_isa_pkg::*;
  import odd_pipe_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  flush,
  input  opcode_e               op,
  input  unit_e                 unit,
  input  logic [`REG_W-1:0]     dst,
  input  logic [3:0]            latency,
  input  logic                  wr,
  input  logic [127:0]          ra,
  input  logic [127:0]          rb,
  input  logic [127:0]          rc,
  input  imm_u                  imm,
  input  logic [`PC_W-1:0]      pc,
  input  logic [127:0]          ls_rdata,
  output logic [`LS_ADDR_W-1:0] ls_addr,
  output logic                  ls_we,
  output logic [127:0]          ls_wdata,
  output pipe_entry_t           entry_in,
  output branch_t               branch
);

  logic [127:0]          shl_result;
  logic [255:0]          rot_wide;
  logic [3:0]            rot_bytes;
  logic [127:0]          perm_result;
  logic [127:0]          br_result;
  logic [127:0]          unit_result;
  logic                  d_form;
  logic [`LS_ADDR_W-1:0] addr_d;
  logic [`LS_ADDR_W-1:0] addr_a;
  logic [`PC_W-1:0]      pc_next;
  logic [`PC_W-1:0]      pc_target;
  logic                  br_taken_c;
  logic                  is_idle;
  logic                  is_br_op;
  logic                  br_valid_q;
  logic                  br_taken_q;
  logic [`PC_W-1:0]      br_pc_q;

  // word 0 / byte 0 sit at the msb end, spu byte order
  assign shl_result = ra << {imm.i7.val[4:0], 3'b000};  // 16 or more bytes clears
  assign rot_bytes  = (op == OP_ROTQBY) ? rb[99:96] : imm.i7.val[3:0];
  assign rot_wide   = {ra, ra} << {rot_bytes, 3'b000};

  assign perm_result = (op == OP_SHLQBYI) ? shl_result : rot_wide[255:128];

  // quadword addresses
  assign d_form = (op == OP_LQD) || (op == OP_STQD);
  assign addr_d = ra[110:100] + {imm.i10.val[9], imm.i10.val};  // ra word 0 >> 4
  assign addr_a = imm.i16.val[12:2];

  assign ls_addr  = d_form ? addr_d : addr_a;
  assign ls_we    = ((op == OP_STQD) || (op == OP_STQA)) && !flush;
  assign ls_wdata = rc;

  // branch unit
  assign pc_next   = pc + `PC_W'(1);
  assign pc_target = pc + imm.i16.val[`PC_W-1:0];

  always_comb begin
    case (op)
      OP_BR:   br_taken_c = 1'b1;
      OP_BRZ:  br_taken_c = (rc[127:96] == 32'd0);
      OP_BRSL: br_taken_c = 1'b1;
      default: br_taken_c = 1'b0;
    endcase
  end

  // brsl links the return pc into word 0
  assign br_result = (op == OP_BRSL) ? {{(32 - `PC_W){1'b0}}, pc_next, 96'd0} : 128'd0;

  always_comb begin
    case (unit)
      UNIT_PERM: unit_result = perm_result;
      UNIT_LS:   unit_result = ls_rdata;   // stores carry it too, wr is low
      UNIT_BR:   unit_result = br_result;
      default:   unit_result = 128'd0;
    endcase
  end

  assign is_idle  = (op == OP_NOP) || (op == OP_LNOP) || flush;
  assign is_br_op = (unit == UNIT_BR) && !is_idle;

  always_comb begin
    if (is_idle) begin
      entry_in = '0;  // bubble into stage 1
    end else begin
      entry_in.unit    = unit;
      entry_in.result  = unit_result;
      entry_in.dst     = dst;
      entry_in.latency = latency;
      entry_in.wr      = wr;
    end
  end

  // branch outcome, one cycle strobe after issue
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      br_valid_q <= 1'b0;
      br_taken_q <= 1'b0;
    end else begin
      br_valid_q <= is_br_op;
      br_taken_q <= is_br_op && br_taken_c;
    end
  end

  always_ff @(posedge clk) begin
    if (is_br_op) begin
      br_pc_q <= br_taken_c ? pc_target : pc_next;
    end
  end

  assign branch = '{is_branch: br_valid_q, taken: br_taken_q, new_pc: br_pc_q};

endmodule

// File: logic/odd_pipe.sv
`include "odd_settings.svh"

module odd_pipe
  import spu_isa_pkg::*;
  import odd_pipe_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  flush,
  input  opcode_e               op,
  input  unit_e                 unit,
  input  logic [`REG_W-1:0]     dst,
  input  logic [3:0]            latency,
  input  logic                  wr,
  input  logic [127:0]          ra,
  input  logic [127:0]          rb,
  input  logic [127:0]          rc,
  input  imm_u                  imm,
  input  logic [`PC_W-1:0]      pc,
  input  fwd_query_t            query,
  input  logic                  preload_en,
  input  logic [`LS_ADDR_W-1:0] preload_addr,
  input  logic [127:0]          preload_data,
  output wb_t                   wb,
  output branch_t               branch,
  output fwd_t                  fwd
);

  logic [`LS_ADDR_W-1:0] ls_addr;
  logic                  ls_we;
  logic [127:0]          ls_wdata;
  logic [127:0]          ls_rdata;
  pipe_entry_t           entry_in;
  pipe_entry_t           stage_entry [1:`ODD_DEPTH];
  logic [2:0]            stage_hit [1:`ODD_DEPTH];

  odd_exec odd_exec_inst (
    .clk      (clk),
    .rst      (rst),
    .flush    (flush),
    .op       (op),
    .unit     (unit),
    .dst      (dst),
    .latency  (latency),
    .wr       (wr),
    .ra       (ra),
    .rb       (rb),
    .rc       (rc),
    .imm      (imm),
    .pc       (pc),
    .ls_rdata (ls_rdata),
    .ls_addr  (ls_addr),
    .ls_we    (ls_we),
    .ls_wdata (ls_wdata),
    .entry_in (entry_in),
    .branch   (branch)
  );

  local_store local_store_inst (
    .clk          (clk),
    .rst          (rst),
    .addr         (ls_addr),
    .we           (ls_we),
    .wdata        (ls_wdata),
    .preload_en   (preload_en),
    .preload_addr (preload_addr),
    .preload_data (preload_data),
    .rdata        (ls_rdata)
  );

  for (genvar k = 1; k <= `ODD_DEPTH; k++) begin : stage_gen
    pipe_entry_t stage_in;

    // stage 1 takes the freshly packed entry
    if (k == 1) begin : g_src
      assign stage_in = entry_in;
    end else begin : g_src
      assign stage_in = stage_entry[k-1];
    end

    pipe_stage #(
      .STAGE (k)
    ) pipe_stage_inst (
      .clk       (clk),
      .rst       (rst),
      .entry_in  (stage_in),
      .query     (query),
      .entry_out (stage_entry[k]),
      .hit       (stage_hit[k])
    );
  end

  result_collect result_collect_inst (
    .clk         (clk),
    .rst         (rst),
    .stage_entry (stage_entry),
    .stage_hit   (stage_hit),
    .fwd         (fwd),
    .wb          (wb)
  );

endmodule

// File: logic/odd_pipe_pkg.sv
`include "odd_settings.svh"

package odd_pipe_pkg;

  import spu_isa_pkg::*;

  // 3 + 128 + 7 + 4 + 1 = 143 bits per entry
  typedef struct packed {
    unit_e              unit;
    logic [127:0]       result;
    logic [`REG_W-1:0]  dst;
    logic [3:0]         latency;  // stage index at which result is final
    logic               wr;
  } pipe_entry_t;

  typedef struct packed {
    logic               en;
    logic [`REG_W-1:0]  addr;
    logic [127:0]       data;
  } wb_t;

  typedef struct packed {
    logic               is_branch;
    logic               taken;
    logic [`PC_W-1:0]   new_pc;
  } branch_t;

  // sources of the instruction being decoded, index 0..2 = a, b, c
  typedef struct packed {
    logic [2:0][`REG_W-1:0] src;
  } fwd_query_t;

  typedef struct packed {
    logic [2:0]         valid;
    logic [2:0][127:0]  data;
  } fwd_t;

endpackage

// File: logic/pipe_stage.sv
module pipe_stage
  import odd_pipe_pkg::*;
#(
  parameter int STAGE = 1
) (
  input  logic        clk,
  input  logic        rst,
  input  pipe_entry_t entry_in,
  input  fwd_query_t  query,
  output pipe_entry_t entry_out,
  output logic [2:0]  hit
);

  localparam logic [3:0] STAGE_IDX = 4'(STAGE);

  pipe_entry_t entry_q;
  logic        ready;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      entry_q <= '0;
    end else begin
      entry_q <= entry_in;
    end
  end

  // result is final once the entry has travelled its latency
  assign ready = entry_q.wr && (STAGE_IDX >= entry_q.latency);

  always_comb begin
    for (int i = 0; i < 3; i++) begin
      hit[i] = ready && (entry_q.dst == query.src[i]);
    end
  end

  assign entry_out = entry_q;

endmodule

// File: logic/result_collect.sv
`include "odd_settings.svh"

module result_collect
  import odd_pipe_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  pipe_entry_t stage_entry [1:`ODD_DEPTH],
  input  logic [2:0]  stage_hit [1:`ODD_DEPTH],
  output fwd_t        fwd,
  output wb_t         wb
);

  pipe_entry_t       last_entry;
  logic              wb_en_q;
  logic [`REG_W-1:0] wb_addr_q;
  logic [127:0]      wb_data_q;

  // scan oldest to youngest so the lowest stage index is left standing
  always_comb begin
    fwd = '0;
    for (int i = 0; i < 3; i++) begin
      for (int k = `ODD_DEPTH; k >= 1; k--) begin
        if (stage_hit[k][i]) begin
          fwd.valid[i] = 1'b1;
          fwd.data[i]  = stage_entry[k].result;
        end
      end
    end
  end

  assign last_entry = stage_entry[`ODD_DEPTH];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wb_en_q <= 1'b0;
    end else begin
      wb_en_q <= last_entry.wr;
    end
  end

  // write-back payload
  always_ff @(posedge clk) begin
    wb_addr_q <= last_entry.dst;
    wb_data_q <= last_entry.result;
  end

  assign wb = '{en: wb_en_q, addr: wb_addr_q, data: wb_data_q};

endmodule

// File: logic/spu_isa_pkg.sv
package spu_isa_pkg;

  // odd pipe opcodes in scope, idle slots use nop or lnop
  typedef enum logic [6:0] {
    OP_SHLQBYI = 7'd16,
    OP_ROTQBYI = 7'd17,
    OP_ROTQBY  = 7'd18,
    OP_LQD     = 7'd32,
    OP_STQD    = 7'd33,
    OP_LQA     = 7'd34,
    OP_STQA    = 7'd35,
    OP_BR      = 7'd48,
    OP_BRZ     = 7'd49,
    OP_BRSL    = 7'd50,
    OP_NOP     = 7'd85,
    OP_LNOP    = 7'd87
  } opcode_e;

  typedef enum logic [2:0] {
    UNIT_PERM = 3'b101,
    UNIT_LS   = 3'b110,
    UNIT_BR   = 3'b111
  } unit_e;

  typedef struct packed {
    logic [10:0] pad;
    logic [6:0]  val;   // byte counts for permute
  } imm7_t;

  typedef struct packed {
    logic [7:0] pad;
    logic [9:0] val;    // signed quadword offset, d-form
  } imm10_t;

  typedef struct packed {
    logic [1:0]  pad;
    logic [15:0] val;   // branch offset or a-form address
  } imm16_t;

  // one immediate word, read by field width per opcode
  typedef union packed {
    imm7_t       i7;
    imm10_t      i10;
    imm16_t      i16;
    logic [17:0] i18;
  } imm_u;

endpackage

// File: test/odd_pipe_tb.sv
`include "odd_settings.svh"

module odd_pipe_tb
  import spu_isa_pkg::*;
  import odd_pipe_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  logic                  clk;
  logic                  rst;
  logic                  flush;
  opcode_e               op;
  unit_e                 unit;
  logic [`REG_W-1:0]     dst;
  logic [3:0]            latency;
  logic                  wr;
  logic [127:0]          ra;
  logic [127:0]          rb;
  logic [127:0]          rc;
  imm_u                  imm;
  logic [`PC_W-1:0]      pc;
  fwd_query_t            query;
  logic                  preload_en;
  logic [`LS_ADDR_W-1:0] preload_addr;
  logic [127:0]          preload_data;
  wb_t                   wb;
  branch_t               branch;
  fwd_t                  fwd;
  int                    cycle_count = 0;

  odd_pipe odd_pipe_inst (
    .clk          (clk),
    .rst          (rst),
    .flush        (flush),
    .op           (op),
    .unit         (unit),
    .dst          (dst),
    .latency      (latency),
    .wr           (wr),
    .ra           (ra),
    .rb           (rb),
    .rc           (rc),
    .imm          (imm),
    .pc           (pc),
    .query        (query),
    .preload_en   (preload_en),
    .preload_addr (preload_addr),
    .preload_data (preload_data),
    .wb           (wb),
    .branch       (branch),
    .fwd          (fwd)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("TB FAILED");
    $fatal(1, "stopped at first error");
  endtask

  // about six tests of under 200 cycles each with margin
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= 1500) begin
      fail_run($sformatf("timeout: tests still running after %0d cycles", cycle_count));
    end
  end

  // byte 0 is the most significant byte of a quadword
  function automatic logic [7:0] byte_of(input logic [127:0] q, input int idx);
    return q[127 - 8 * idx -: 8];
  endfunction

  function automatic logic [127:0] shift_bytes_left(input logic [127:0] src, input int n);
    logic [127:0] res;
    res = '0;
    for (int b = 0; b < 16; b++) begin
      if (b + n < 16) begin
        res[127 - 8 * b -: 8] = byte_of(src, b + n);  // bytes past the end fill zero
      end
    end
    return res;
  endfunction

  function automatic logic [127:0] rotate_bytes_left(input logic [127:0] src, input int n);
    logic [127:0] res;
    for (int b = 0; b < 16; b++) begin
      res[127 - 8 * b -: 8] = byte_of(src, (b + n) % 16);
    end
    return res;
  endfunction

  function automatic logic [127:0] random_quad();
    return {$urandom(), $urandom(), $urandom(), $urandom()};
  endfunction

  function automatic wb_t make_wb(input logic [`REG_W-1:0] addr, input logic [127:0] data);
    wb_t w;
    w.en   = 1'b1;
    w.addr = addr;
    w.data = data;
    return w;
  endfunction

  task automatic tick();
    @(posedge clk);
    #2;
  endtask

  task automatic settle();
    @(negedge clk);
  endtask

  task automatic drive_idle();
    flush        = 1'b0;
    op           = OP_NOP;
    unit         = UNIT_PERM;
    dst          = '0;
    latency      = '0;
    wr           = 1'b0;
    ra           = '0;
    rb           = '0;
    rc           = '0;
    imm          = '0;
    pc           = '0;
    preload_en   = 1'b0;
    preload_addr = '0;
    preload_data = '0;
  endtask

  // one instruction in the slot of the next edge
  task automatic issue(input opcode_e o, input unit_e u, input logic [`REG_W-1:0] d,
                       input logic [3:0] lat, input logic w, input logic [127:0] a,
                       input logic [127:0] b, input logic [127:0] c, input imm_u im,
                       input logic [`PC_W-1:0] p, input logic fl);
    tick();
    op      = o;
    unit    = u;
    dst     = d;
    latency = lat;
    wr      = w;
    ra      = a;
    rb      = b;
    rc      = c;
    imm     = im;
    pc      = p;
    flush   = fl;
  endtask

  task automatic preload_quad(input logic [`LS_ADDR_W-1:0] addr, input logic [127:0] data);
    tick();
    drive_idle();
    preload_en   = 1'b1;
    preload_addr = addr;
    preload_data = data;
    tick();
    drive_idle();
  endtask

  task automatic check_wb(input wb_t exp);
    if (wb.en !== exp.en) begin
      fail_run($sformatf("MISMATCH at %0t ns: wb.en expected %b got %b",
                         $time, exp.en, wb.en));
    end else if (exp.en && wb.addr !== exp.addr) begin
      fail_run($sformatf("MISMATCH at %0t ns: wb.addr expected %0d got %0d",
                         $time, exp.addr, wb.addr));
    end else if (exp.en && wb.data !== exp.data) begin
      fail_run($sformatf("MISMATCH at %0t ns: wb.data expected %h got %h",
                         $time, exp.data, wb.data));
    end
  endtask

  task automatic check_branch(input branch_t exp);
    if (branch.is_branch !== exp.is_branch) begin
      fail_run($sformatf("MISMATCH at %0t ns: branch.is_branch expected %b got %b",
                         $time, exp.is_branch, branch.is_branch));
    end else if (branch.taken !== exp.taken) begin
      fail_run($sformatf("MISMATCH at %0t ns: branch.taken expected %b got %b",
                         $time, exp.taken, branch.taken));
    end else if (exp.is_branch && branch.new_pc !== exp.new_pc) begin
      fail_run($sformatf("MISMATCH at %0t ns: branch.new_pc expected %0d got %0d",
                         $time, exp.new_pc, branch.new_pc));
    end
  endtask

  task automatic check_fwd(input fwd_t exp);
    for (int i = 0; i < 3; i++) begin
      if (fwd.valid[i] !== exp.valid[i]) begin
        fail_run($sformatf("MISMATCH at %0t ns: fwd.valid[%0d] expected %b got %b",
                           $time, i, exp.valid[i], fwd.valid[i]));
      end else if (exp.valid[i] && fwd.data[i] !== exp.data[i]) begin
        fail_run($sformatf("MISMATCH at %0t ns: fwd.data[%0d] expected %h got %h",
                           $time, i, exp.data[i], fwd.data[i]));
      end
    end
  endtask

  // idles until wb.en rises and checks the arrival cycle
  task automatic wait_wb(input int exp_cycles, input wb_t exp);
    int n;
    n = 0;
    do begin
      tick();
      drive_idle();
      settle();
      n++;
    end while (!wb.en && n < exp_cycles + 4);
    if (n != exp_cycles) begin
      fail_run($sformatf("write-back came %0d cycles after issue, expected after %0d",
                         n, exp_cycles));
    end
    check_wb(exp);
  endtask

  task automatic drain(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      tick();
      drive_idle();
      settle();
      check_wb('0);
      check_branch('0);
    end
  endtask

  task automatic test_reset();
    rst = 1'b1;
    for (int i = 0; i < 12; i++) begin
      if (i == 7) begin
        rst = 1'b0;  // held for 8 cycles
      end
      for (int s = 0; s < 3; s++) begin
        query.src[s] = `REG_W'($urandom());
      end
      settle();
      check_wb('0);
      check_branch('0);
      check_fwd('0);
      tick();
    end
  endtask

  task automatic test_permute();
    logic [127:0]      a;
    logic [127:0]      b;
    logic [`REG_W-1:0] d;
    imm_u              im;
    int                n;
    wb_t               exp;
    for (int i = 0; i < 12; i++) begin
      a = random_quad();
      b = random_quad();
      d = `REG_W'($urandom());
      im = '0;
      im.i7.val = 7'($urandom());
      case (i % 3)
        0: begin
          n = int'(im.i7.val) % 32;  // 16 and up clears the quadword
          exp = make_wb(d, shift_bytes_left(a, n));
          issue(OP_SHLQBYI, UNIT_PERM, d, 4'd2, 1'b1, a, b, '0, im, '0, 1'b0);
        end
        1: begin
          n = int'(im.i7.val) % 16;
          exp = make_wb(d, rotate_bytes_left(a, n));
          issue(OP_ROTQBYI, UNIT_PERM, d, 4'd2, 1'b1, a, b, '0, im, '0, 1'b0);
        end
        default: begin
          n = byte_of(b, 3) % 16;  // count from rb byte 3
          exp = make_wb(d, rotate_bytes_left(a, n));
          issue(OP_ROTQBY, UNIT_PERM, d, 4'd2, 1'b1, a, b, '0, im, '0, 1'b0);
        end
      endcase
      wait_wb(8, exp);
    end
  endtask

  task automatic test_local_store();
    logic [`LS_ADDR_W-1:0] p_addr;
    logic [127:0]          p_data;
    logic [127:0]          a;
    logic [127:0]          c;
    logic [`REG_W-1:0]     d;
    imm_u                  im;
    int                    qaddr;
    p_addr = `LS_ADDR_W'($urandom());
    p_data = random_quad();
    d = `REG_W'($urandom());
    preload_quad(p_addr, p_data);
    im = '0;
    im.i16.val = 16'(int'(p_addr) * 4);  // a-form immediate is four per quadword
    issue(OP_LQA, UNIT_LS, d, 4'd6, 1'b1, '0, '0, '0, im, '0, 1'b0);
    wait_wb(8, make_wb(d, p_data));

    a = random_quad();
    c = random_quad();
    im = '0;
    im.i10.val = 10'($urandom());
    qaddr = (int'(a[127:96] >> 4) + int'($signed(im.i10.val))) & 'h7ff;
    issue(OP_STQD, UNIT_LS, '0, 4'd6, 1'b0, a, '0, c, im, '0, 1'b0);
    issue(OP_LQD, UNIT_LS, d, 4'd6, 1'b1, a, '0, '0, im, '0, 1'b0);  // store one edge back
    wait_wb(8, make_wb(d, c));
    im = '0;
    im.i16.val = 16'(qaddr * 4);
    issue(OP_LQA, UNIT_LS, d, 4'd6, 1'b1, '0, '0, '0, im, '0, 1'b0);
    wait_wb(8, make_wb(d, c));
  endtask

  task automatic branch_once(input opcode_e o, input logic [127:0] c, input logic exp_taken);
    logic [`PC_W-1:0]  p;
    logic [`PC_W-1:0]  ret;
    logic [`REG_W-1:0] d;
    logic [127:0]      link;
    imm_u              im;
    branch_t           exp;
    p = `PC_W'($urandom());
    d = `REG_W'($urandom());
    im = '0;
    im.i16.val = 16'($urandom());
    ret = `PC_W'(p + 1);
    exp.is_branch = 1'b1;
    exp.taken = exp_taken;
    exp.new_pc = exp_taken ? `PC_W'(p + im.i16.val) : ret;
    issue(o, UNIT_BR, d, 4'd1, o == OP_BRSL, '0, '0, c, im, p, 1'b0);
    tick();
    drive_idle();
    settle();
    check_branch(exp);
    if (o == OP_BRSL) begin
      link = '0;
      link[127:96] = 32'(ret);  // return pc in word 0
      wait_wb(7, make_wb(d, link));
    end else begin
      tick();
      settle();
      check_branch('0);  // strobe lasts one cycle
    end
  endtask

  task automatic test_branch();
    logic [127:0] c;
    branch_once(OP_BR, random_quad(), 1'b1);
    c = random_quad();
    c[127:96] = '0;
    branch_once(OP_BRZ, c, 1'b1);
    c[127:96] = $urandom() | 32'd1;
    branch_once(OP_BRZ, c, 1'b0);
    branch_once(OP_BRSL, random_quad(), 1'b1);
    drain(3);
  endtask

  task automatic test_forwarding();
    logic [`REG_W-1:0] r;
    logic [127:0]      data_a;
    logic [127:0]      data_b;
    imm_u              im;
    fwd_t              exp;
    int                stage_a;
    int                stage_b;
    logic              ok_a;
    logic              ok_b;
    r = `REG_W'($urandom());
    data_a = random_quad();
    data_b = random_quad();
    im = '0;  // shift by zero passes ra through
    issue(OP_SHLQBYI, UNIT_PERM, r, 4'd4, 1'b1, data_a, '0, '0, im, '0, 1'b0);
    query.src[0] = r;
    query.src[1] = `REG_W'(r + 1);  // never written
    query.src[2] = r;
    issue(OP_SHLQBYI, UNIT_PERM, r, 4'd6, 1'b1, data_b, '0, '0, im, '0, 1'b0);
    for (int j = 0; j < 10; j++) begin
      if (j > 0) begin
        tick();
        drive_idle();
      end
      settle();
      stage_a = j + 1;  // older entry with latency 4
      stage_b = j;      // younger entry with latency 6
      ok_a = (stage_a <= `ODD_DEPTH) && (stage_a >= 4);
      ok_b = (stage_b >= 1) && (stage_b <= `ODD_DEPTH) && (stage_b >= 6);
      exp = '0;
      for (int i = 0; i < 3; i += 2) begin
        exp.valid[i] = ok_a || ok_b;
        exp.data[i] = ok_b ? data_b : data_a;  // younger one wins
      end
      check_fwd(exp);
      if (j == 7) begin
        check_wb(make_wb(r, data_a));
      end else if (j == 8) begin
        check_wb(make_wb(r, data_b));
      end else begin
        check_wb('0);
      end
    end
    tick();
    query = '0;
  endtask

  task automatic test_flush();
    logic [`LS_ADDR_W-1:0] s;
    logic [127:0]          keep;
    logic [127:0]          a;
    logic [`REG_W-1:0]     d;
    imm_u                  im;
    s = `LS_ADDR_W'($urandom());
    keep = random_quad();
    a = random_quad();
    d = `REG_W'($urandom());
    preload_quad(s, keep);
    im = '0;
    im.i7.val = 7'd3;
    issue(OP_ROTQBYI, UNIT_PERM, d, 4'd3, 1'b1, a, '0, '0, im, '0, 1'b0);  // older one survives
    im = '0;
    im.i16.val = 16'd40;
    issue(OP_BR, UNIT_BR, '0, 4'd1, 1'b0, '0, '0, '0, im, 10'd5, 1'b1);
    im.i16.val = 16'(int'(s) * 4);
    issue(OP_STQA, UNIT_LS, '0, 4'd6, 1'b0, '0, '0, random_quad(), im, '0, 1'b1);
    settle();
    check_branch('0);
    issue(OP_BRSL, UNIT_BR, `REG_W'(d + 1), 4'd1, 1'b1, '0, '0, '0, im, 10'd9, 1'b1);
    tick();
    drive_idle();
    settle();
    check_branch('0);
    wait_wb(4, make_wb(d, rotate_bytes_left(a, 3)));
    drain(6);
    issue(OP_LQA, UNIT_LS, d, 4'd6, 1'b1, '0, '0, '0, im, '0, 1'b0);
    wait_wb(8, make_wb(d, keep));  // squashed store left it alone
  endtask

  initial begin
    void'($urandom(37));
    rst = 1'b1;
    drive_idle();
    query = '0;
    test_reset();
    drain(2);
    test_permute();
    drain(3);
    test_local_store();
    drain(3);
    test_branch();
    test_forwarding();
    test_flush();
    drain(3);
    $display("TB PASSED");
    $finish;
  end

endmodule
